//--- sim.f
hdl/core_pkg.sv
hdl/core_decode_conds.sv
hdl/core_decode_snd.sv
hdl/core_decode_data.sv
hdl/core_decode_ldst.sv
hdl/core_decode.sv
hdl/core_decode_stage.sv
testbench/tb_core_decode.sv

//--- Makefile
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sim.f --top-module core_decode_stage
	verilator --lint-only --timing --assert -f sim.f --top-module tb_core_decode

sim:
	verilator --binary --timing --assert -j 0 -Mdir obj_dir -f sim.f --top-module tb_core_decode
	./obj_dir/Vtb_core_decode | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_core_decode.sv
`timescale 1ns/1ps

module tb_core_decode import core_pkg::*; ();

	localparam int N_RANDOM = 600;
	localparam int RUN_CYCLES = 300 + 2 * N_RANDOM; // reset, sweep, corners, random and gaps
	localparam logic [31:0] CORNERS [10] = '{
		32'hee000010, 32'hef000000, 32'he1000090, 32'he10f0000, 32'he0810190,
		32'he6901010, 32'he4e01000, 32'he8d0000f, 32'hebfffffe, 32'he1500001
	};

	typedef struct packed {
		logic execute, undefined, conditional, writeback, update_flags;
		logic [3:0] kind; // branch, ldst, ldm, mul
		logic [3:0] alu_op;
		logic [7:0] regs; // rd, rn
		logic uses_rn;
		logic [16:0] imm_op; // snd_is_imm, snd_imm, snd_rot
		logic [3:0] snd_r, snd_rs;
		logic [8:0] shift_op; // snd_is_imm, shift_type, shift_imm, shift_by_reg
		logic [29:0] branch_offset;
		logic [4:0] ls_op; // load, byte, pre, up, ldst_writeback
		logic ldm_wb;
		logic [15:0] ldm_mask;
		logic chk_alu, chk_regs, chk_uses, chk_imm, chk_sndr, chk_shift, chk_rs;
		logic chk_boff, chk_ls, chk_ldm;
	} expected_t;

	logic clk = 1'b0;
	logic arst_n, insn_valid, out_valid;
	logic [31:0] insn;
	logic [3:0] flags;
	logic execute, undefined, conditional, writeback, update_flags;
	logic branch, ldst, ldm, mul, uses_rn, snd_is_imm, shift_by_reg;
	logic ldst_load, ldst_byte, ldst_pre, ldst_up, ldst_writeback;
	alu_op_t alu_op;
	reg_num rd, rn, snd_r, snd_rs;
	logic [11:0] snd_imm;
	logic [3:0] snd_rot;
	shift_t shift_type;
	logic [4:0] shift_imm;
	logic [29:0] branch_offset;
	logic [15:0] ldm_mask;
	expected_t want;
	integer seed;

	always #10 clk = ~clk;

	core_decode_stage core_decode_stage_inst (.*);

	function automatic expected_t reference_decode(input logic [31:0] w,
			input logic [3:0] nzcv);
		expected_t e;
		logic n, z, c, v, base, undef, is_cmp;
		insn_group_t grp;
		e = '0;
		{n, z, c, v} = nzcv;
		case (w[31:29])
			3'd0: base = z;
			3'd1: base = c;
			3'd2: base = n;
			3'd3: base = v;
			3'd4: base = c & ~z;
			3'd5: base = (n == v);
			3'd6: base = ~z & (n == v);
			default: base = 1'b1;
		endcase
		e.execute = (w[28] && w[31:29] != 3'd7) ? ~base : base; // odd codes invert
		e.conditional = (w[31:28] != 4'he);
		undef = (w[31:28] == 4'hf);
		if (w[27:25] == 3'b101)
			grp = G_BRANCH;
		else if (w[27:22] == 6'd0 && w[7:4] == 4'b1001)
			grp = G_MUL;
		else if (w[27:25] == 3'b100)
			grp = G_LDM;
		else if (w[27:26] == 2'b01)
			grp = G_LDST;
		else if (w[27:26] == 2'b00 && w[24:23] == 2'b10 && !w[20])
			grp = G_UNDEF; // psr transfer and swap
		else if (w[27:26] == 2'b00)
			grp = G_DATA;
		else
			grp = G_UNDEF;
		case (grp)
			G_DATA: begin
				is_cmp = (w[24:23] == 2'b10);
				e.alu_op = w[24:21];
				e.regs = {w[15:12], w[19:16]};
				{e.chk_alu, e.chk_regs, e.chk_uses} = 3'b111;
				e.uses_rn = (w[24:21] != 4'hd) && (w[24:21] != 4'hf);
				e.writeback = !is_cmp;
				e.update_flags = is_cmp | w[20];
				if (w[25]) begin
					e.imm_op = {1'b1, 4'h0, w[7:0], w[11:8]};
					e.chk_imm = 1'b1;
				end else begin
					e.snd_r = w[3:0];
					e.shift_op = {1'b0, w[6:5], w[4] ? 5'd0 : w[11:7], w[4]};
					e.snd_rs = w[11:8];
					{e.chk_sndr, e.chk_shift, e.chk_rs} = {2'b11, w[4]};
					undef |= w[4] & w[7];
				end
			end
			G_BRANCH: begin
				e.kind = 4'b1000;
				e.branch_offset = {{6{w[23]}}, w[23:0]};
				e.chk_boff = 1'b1;
				if (w[24]) begin
					{e.alu_op, e.regs, e.chk_alu, e.chk_regs} = {SUB, R14, R15, 2'b11};
					e.imm_op = {1'b1, 12'd4, 4'd0};
					e.chk_imm = 1'b1;
					e.writeback = 1'b1;
				end
			end
			G_MUL: begin
				e.kind = 4'b0001;
				{e.regs, e.snd_r, e.uses_rn} = {w[19:16], w[11:8], w[3:0], w[21]};
				{e.chk_regs, e.chk_sndr, e.chk_uses} = 3'b111;
				e.writeback = 1'b1;
				e.update_flags = w[20];
			end
			G_LDM: begin
				e.kind = 4'b0010;
				{e.ldm_mask, e.ldm_wb, e.chk_ldm} = {w[15:0], w[21], 1'b1};
				e.writeback = w[21] | w[20];
				e.imm_op = {1'b1, 12'd4, 4'd0};
				e.chk_imm = 1'b1;
				undef |= w[22]; // user bank transfer
			end
			G_LDST: begin
				e.kind = 4'b0100;
				{e.regs, e.chk_regs, e.chk_ls} = {w[15:12], w[19:16], 2'b11};
				e.ls_op = {w[20], w[22], w[24], w[23], w[21] | ~w[24]};
				e.writeback = w[21] | ~w[24] | w[20];
				if (!w[25]) begin
					e.imm_op = {1'b1, w[11:0], 4'd0};
					e.chk_imm = 1'b1;
				end else begin
					e.snd_r = w[3:0];
					e.chk_sndr = 1'b1;
					undef |= w[4];
				end
				undef |= ~w[24] & w[21] & w[22]; // byte access with translation
			end
			default: undef = 1'b1;
		endcase
		e.undefined = undef;
		e.execute = e.execute & ~undef;
		return e;
	endfunction

	function automatic logic [31:0] build_insn(input int cls, input logic [31:0] r);
		case (cls)
			0: return {r[31:28], 2'b00, r[25:0]};
			1: return {r[31:28], 3'b101, r[24:0]};
			2: return {r[31:28], 6'b000000, r[21:8], 4'b1001, r[3:0]};
			3: return {r[31:28], 2'b01, r[25:0]};
			4: return {r[31:28], 3'b100, r[24:0]};
			default: return {r[31:28], 2'b11, r[25:0]}; // coprocessor and swi
		endcase
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp_val);
		$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp_val);
		$display("TEST FAILED");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic send_insn(input logic [31:0] word, input logic [3:0] nzcv);
		insn_valid <= 1'b1;
		insn <= word;
		flags <= nzcv;
		@(posedge clk);
	endtask

	always @(posedge clk)
		if (insn_valid)
			want <= reference_decode(insn, flags); // lines up with the registered outputs

	assert property (@(posedge clk) out_valid |-> execute == want.execute)
		else report_mismatch("execute", $sampled(execute), $sampled(want.execute));
	assert property (@(posedge clk) out_valid |-> undefined == want.undefined)
		else report_mismatch("undefined", $sampled(undefined), $sampled(want.undefined));
	assert property (@(posedge clk) out_valid |-> conditional == want.conditional)
		else report_mismatch("conditional", $sampled(conditional),
			$sampled(want.conditional));
	assert property (@(posedge clk) out_valid |-> writeback == want.writeback)
		else report_mismatch("writeback", $sampled(writeback), $sampled(want.writeback));
	assert property (@(posedge clk) out_valid |-> update_flags == want.update_flags)
		else report_mismatch("update_flags", $sampled(update_flags),
			$sampled(want.update_flags));
	assert property (@(posedge clk) out_valid |-> {branch, ldst, ldm, mul} == want.kind)
		else report_mismatch("branch/ldst/ldm/mul", $sampled({branch, ldst, ldm, mul}),
			$sampled(want.kind));
	assert property (@(posedge clk) out_valid && want.chk_alu |-> alu_op == want.alu_op)
		else report_mismatch("alu_op", $sampled(alu_op), $sampled(want.alu_op));
	assert property (@(posedge clk) out_valid && want.chk_regs |-> {rd, rn} == want.regs)
		else report_mismatch("rd/rn", $sampled({rd, rn}), $sampled(want.regs));
	assert property (@(posedge clk) out_valid && want.chk_uses |-> uses_rn == want.uses_rn)
		else report_mismatch("uses_rn", $sampled(uses_rn), $sampled(want.uses_rn));
	assert property (@(posedge clk) out_valid && want.chk_imm |->
		{snd_is_imm, snd_imm, snd_rot} == want.imm_op)
		else report_mismatch("snd_is_imm/snd_imm/snd_rot",
			$sampled({snd_is_imm, snd_imm, snd_rot}), $sampled(want.imm_op));
	assert property (@(posedge clk) out_valid && want.chk_sndr |-> snd_r == want.snd_r)
		else report_mismatch("snd_r", $sampled(snd_r), $sampled(want.snd_r));
	assert property (@(posedge clk) out_valid && want.chk_shift |->
		{snd_is_imm, shift_type, shift_imm, shift_by_reg} == want.shift_op)
		else report_mismatch("snd_is_imm/shift_type/shift_imm/shift_by_reg",
			$sampled({snd_is_imm, shift_type, shift_imm, shift_by_reg}),
			$sampled(want.shift_op));
	assert property (@(posedge clk) out_valid && want.chk_rs |-> snd_rs == want.snd_rs)
		else report_mismatch("snd_rs", $sampled(snd_rs), $sampled(want.snd_rs));
	assert property (@(posedge clk) out_valid && want.chk_boff |->
		branch_offset == want.branch_offset)
		else report_mismatch("branch_offset", $sampled(branch_offset),
			$sampled(want.branch_offset));
	assert property (@(posedge clk) out_valid && want.chk_ls |->
		{ldst_load, ldst_byte, ldst_pre, ldst_up, ldst_writeback} == want.ls_op)
		else report_mismatch("ldst_load/byte/pre/up/writeback",
			$sampled({ldst_load, ldst_byte, ldst_pre, ldst_up, ldst_writeback}),
			$sampled(want.ls_op));
	assert property (@(posedge clk) out_valid && want.chk_ldm |->
		{ldm_mask, ldst_writeback} == {want.ldm_mask, want.ldm_wb})
		else report_mismatch("ldm_mask/ldst_writeback", $sampled({ldm_mask, ldst_writeback}),
			$sampled({want.ldm_mask, want.ldm_wb}));
	assert property (@(posedge clk) disable iff (!arst_n) insn_valid |=> out_valid)
		else report_mismatch("out_valid", $sampled(out_valid), 32'h1);
	assert property (@(posedge clk) disable iff (!arst_n) !insn_valid |=> !out_valid)
		else report_mismatch("out_valid", $sampled(out_valid), 32'h0);
	assert property (@(posedge clk) !arst_n |-> {out_valid, execute, writeback} == 3'b000)
		else report_mismatch("out_valid/execute/writeback in reset",
			$sampled({out_valid, execute, writeback}), 32'h0);

	initial begin
		#(RUN_CYCLES * 20);
		$display("timeout: decode run did not complete in time");
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		int cls;
		logic [31:0] r;
		seed = 5;
		arst_n = 1'b0;
		insn_valid = 1'b0;
		insn = 32'd0;
		flags = 4'd0;
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		for (int c = 0; c < 16; c++)
			for (int f = 0; f < 16; f++)
				send_insn({4'(c), 28'h3a01000}, 4'(f)); // mov r1, #0 under every condition
		foreach (CORNERS[i])
			send_insn(CORNERS[i], 4'h0);
		for (int k = 0; k < N_RANDOM; k++) begin
			cls = $unsigned($random(seed)) % 6;
			r = $random(seed);
			send_insn(build_insn(cls, r), 4'($random(seed)));
			if (k % 7 == 6) begin
				insn_valid <= 1'b0; // bubble
				@(posedge clk);
			end
		end
		send_insn(32'he3a01000, 4'h0); // leaves execute and writeback high
		insn_valid <= 1'b0;
		@(posedge clk);
		arst_n <= 1'b0; // reset in the middle of the run
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		repeat (3) @(posedge clk);
		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- hdl/core_decode_stage.sv
`timescale 1ns/1ps

module core_decode_stage import core_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        insn_valid,
	input  logic [31:0] insn,
	input  logic [3:0]  flags,

	output logic        out_valid,
	output logic        execute, undefined, conditional,
	output logic        writeback, update_flags,
	output logic        branch, ldst, ldm, mul,
	output alu_op_t     alu_op,
	output reg_num      rd, rn,
	output logic        uses_rn,
	output logic        snd_is_imm,
	output logic [11:0] snd_imm,
	output logic [3:0]  snd_rot,
	output reg_num      snd_r,
	output shift_t      shift_type,
	output logic [4:0]  shift_imm,
	output logic        shift_by_reg,
	output reg_num      snd_rs,
	output logic [29:0] branch_offset,
	output logic        ldst_load, ldst_byte, ldst_pre, ldst_up, ldst_writeback,
	output logic [15:0] ldm_mask
);

	logic d_execute, d_undefined, d_conditional, d_writeback, d_update_flags;
	logic d_branch, d_ldst, d_ldm, d_mul, d_uses_rn, d_snd_is_imm, d_shift_by_reg;
	logic d_ldst_load, d_ldst_byte, d_ldst_pre, d_ldst_up, d_ldst_writeback;
	alu_op_t d_alu_op;
	reg_num d_rd, d_rn, d_snd_r, d_snd_rs;
	logic [11:0] d_snd_imm;
	logic [3:0] d_snd_rot;
	shift_t d_shift_type;
	logic [4:0] d_shift_imm;
	logic [29:0] d_branch_offset;
	logic [15:0] d_ldm_mask;

	core_decode decode (
		.insn(insn), .flags(flags),
		.execute(d_execute), .undefined(d_undefined), .conditional(d_conditional),
		.writeback(d_writeback), .update_flags(d_update_flags),
		.branch(d_branch), .ldst(d_ldst), .ldm(d_ldm), .mul(d_mul),
		.alu_op(d_alu_op), .rd(d_rd), .rn(d_rn), .uses_rn(d_uses_rn),
		.snd_is_imm(d_snd_is_imm), .snd_imm(d_snd_imm), .snd_rot(d_snd_rot),
		.snd_r(d_snd_r), .shift_type(d_shift_type), .shift_imm(d_shift_imm),
		.shift_by_reg(d_shift_by_reg), .snd_rs(d_snd_rs),
		.branch_offset(d_branch_offset),
		.ldst_load(d_ldst_load), .ldst_byte(d_ldst_byte), .ldst_pre(d_ldst_pre),
		.ldst_up(d_ldst_up), .ldst_writeback(d_ldst_writeback),
		.ldm_mask(d_ldm_mask)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			execute <= 1'b0;
			undefined <= 1'b0;
			conditional <= 1'b0;
			writeback <= 1'b0;
			update_flags <= 1'b0;
			branch <= 1'b0;
			ldst <= 1'b0;
			ldm <= 1'b0;
			mul <= 1'b0;
		end else begin
			out_valid <= insn_valid;
			if (insn_valid) begin
				execute <= d_execute;
				undefined <= d_undefined;
				conditional <= d_conditional;
				writeback <= d_writeback;
				update_flags <= d_update_flags;
				branch <= d_branch;
				ldst <= d_ldst;
				ldm <= d_ldm;
				mul <= d_mul;
			end
		end
	end

	// operand and addressing fields
	always_ff @(posedge clk) begin
		if (insn_valid) begin
			alu_op <= d_alu_op;
			rd <= d_rd;
			rn <= d_rn;
			uses_rn <= d_uses_rn;
			snd_is_imm <= d_snd_is_imm;
			snd_imm <= d_snd_imm;
			snd_rot <= d_snd_rot;
			snd_r <= d_snd_r;
			shift_type <= d_shift_type;
			shift_imm <= d_shift_imm;
			shift_by_reg <= d_shift_by_reg;
			snd_rs <= d_snd_rs;
			branch_offset <= d_branch_offset;
			ldst_load <= d_ldst_load;
			ldst_byte <= d_ldst_byte;
			ldst_pre <= d_ldst_pre;
			ldst_up <= d_ldst_up;
			ldst_writeback <= d_ldst_writeback;
			ldm_mask <= d_ldm_mask;
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n) !(execute && undefined));

endmodule

//--- hdl/core_decode.sv
`timescale 1ns/1ps

module core_decode import core_pkg::*; (
	input  logic [31:0] insn,
	input  logic [3:0]  flags,

	output logic        execute, undefined, conditional,
	output logic        writeback, update_flags,
	output logic        branch, ldst, ldm, mul,
	output alu_op_t     alu_op,
	output reg_num      rd, rn,
	output logic        uses_rn,
	output logic        snd_is_imm,
	output logic [11:0] snd_imm,
	output logic [3:0]  snd_rot,
	output reg_num      snd_r,
	output shift_t      shift_type,
	output logic [4:0]  shift_imm,
	output logic        shift_by_reg,
	output reg_num      snd_rs,
	output logic [29:0] branch_offset,
	output logic        ldst_load, ldst_byte, ldst_pre, ldst_up, ldst_writeback,
	output logic [15:0] ldm_mask
);

	insn_group_t group;

	logic cond_pass, cond_undef, explicit_cond;

	core_decode_conds conds (
		.cond(cond_t'(insn[COND_MSB:COND_LSB])),
		.flags(flags),
		.execute(cond_pass),
		.undefined(cond_undef),
		.conditional(explicit_cond)
	);

	logic snd_sel_imm, snd_sel_ror;
	logic op2_is_imm, op2_shift_by_reg, snd_undefined;
	logic [11:0] op2_imm;
	logic [3:0] op2_rot;
	logic [4:0] op2_shift_imm;
	reg_num op2_r, op2_rs;
	shift_t op2_shift_type;

	core_decode_snd snd_operand (
		.insn(insn),
		.is_imm(snd_sel_imm),
		.ror_if_imm(snd_sel_ror),
		.snd_is_imm(op2_is_imm),
		.imm(op2_imm),
		.rot(op2_rot),
		.r(op2_r),
		.shift_type(op2_shift_type),
		.shift_imm(op2_shift_imm),
		.shift_by_reg(op2_shift_by_reg),
		.rs(op2_rs),
		.undefined(snd_undefined)
	);

	alu_op_t data_op;
	reg_num data_rd, data_rn;
	logic data_uses_rn, data_writeback, data_update_flags, data_is_imm, data_shift_by_reg;

	core_decode_data group_data (
		.insn(insn),
		.op(data_op),
		.rd(data_rd),
		.rn(data_rn),
		.uses_rn(data_uses_rn),
		.writeback(data_writeback),
		.update_flags(data_update_flags),
		.is_imm(data_is_imm),
		.shift_by_reg(data_shift_by_reg)
	);

	logic ls_load, ls_byte, ls_pre, ls_up, ls_writeback, ls_offset_is_imm, ls_undefined;
	reg_num ls_rd, ls_rn;

	core_decode_ldst group_ldst (
		.insn(insn),
		.load(ls_load),
		.byte_access(ls_byte),
		.pre_index(ls_pre),
		.up(ls_up),
		.writeback(ls_writeback),
		.rd(ls_rd),
		.rn(ls_rn),
		.offset_is_imm(ls_offset_is_imm),
		.undefined(ls_undefined)
	);

	// mul and psr space sit inside the data-processing encodings and are matched first
	always_comb begin
		priority casez ({insn[27:20], insn[7:4]})
			12'b101?_????_????: group = G_BRANCH;
			12'b0000_00??_1001: group = G_MUL;
			12'b100?_????_????: group = G_LDM;
			12'b01??_????_????: group = G_LDST;
			12'b00?1_0??0_????: group = G_UNDEF; // mrs/msr, not supported
			12'b00??_????_????: group = G_DATA;
			default:            group = G_UNDEF; // coproc, swi
		endcase
	end

	assign snd_sel_imm = (group == G_LDST) ? ls_offset_is_imm : data_is_imm;
	assign snd_sel_ror = (group != G_LDST); // ldst offset is a plain 12-bit value

	always_comb begin
		undefined = cond_undef;
		conditional = explicit_cond;
		writeback = 1'b0;
		update_flags = 1'b0;
		branch = 1'b0;
		ldst = 1'b0;
		ldm = 1'b0;
		mul = 1'b0;

		alu_op = data_op;
		rd = data_rd;
		rn = data_rn;
		uses_rn = 1'b1;

		snd_is_imm = op2_is_imm;
		snd_imm = op2_imm;
		snd_rot = op2_rot;
		snd_r = op2_r;
		shift_type = op2_shift_type;
		shift_imm = op2_shift_imm;
		shift_by_reg = op2_shift_by_reg;
		snd_rs = op2_rs;

		branch_offset = {{6{insn[23]}}, insn[23:0]};

		ldst_load = ls_load;
		ldst_byte = ls_byte;
		ldst_pre = ls_pre;
		ldst_up = ls_up;
		ldst_writeback = ls_writeback;
		ldm_mask = insn[15:0];

		unique case (group)
			G_BRANCH: begin
				branch = 1'b1;
				if (insn[24]) begin
					// bl writes pc - 4 to lr
					alu_op = SUB;
					rd = R14;
					rn = R15;
					snd_is_imm = 1'b1;
					snd_imm = 12'd4;
					snd_rot = 4'd0;
					shift_by_reg = 1'b0;
					writeback = 1'b1;
				end
			end

			G_MUL: begin
				mul = 1'b1;
				rd = insn[RN_MSB:RN_LSB];
				rn = insn[RS_MSB:RS_LSB];
				uses_rn = insn[21]; // accumulate
				snd_is_imm = 1'b0;
				snd_r = insn[RM_MSB:RM_LSB];
				shift_type = LSL;
				shift_imm = 5'd0;
				shift_by_reg = 1'b0;
				writeback = 1'b1;
				update_flags = insn[20];
			end

			G_LDM: begin
				ldm = 1'b1;
				snd_is_imm = 1'b1;
				snd_imm = 12'd4; // one word per register
				snd_rot = 4'd0;
				shift_by_reg = 1'b0;
				ldst_writeback = insn[21];
				writeback = insn[21] || insn[20];
				undefined = undefined || insn[22]; // user bank / spsr restore
			end

			G_LDST: begin
				ldst = 1'b1;
				alu_op = ls_up ? ADD : SUB;
				rd = ls_rd;
				rn = ls_rn;
				writeback = ls_writeback || ls_load;
				undefined = undefined || ls_undefined || snd_undefined;
			end

			G_DATA: begin
				uses_rn = data_uses_rn;
				writeback = data_writeback;
				update_flags = data_update_flags;
				shift_by_reg = !data_is_imm && data_shift_by_reg;
				undefined = undefined || snd_undefined;
			end

			default:
				undefined = 1'b1;
		endcase

		execute = cond_pass && !undefined;
	end

endmodule

//--- hdl/core_decode_ldst.sv
`timescale 1ns/1ps

module core_decode_ldst import core_pkg::*; (
	input  logic [31:0] insn,

	output logic        load,
	output logic        byte_access,
	output logic        pre_index,
	output logic        up,
	output logic        writeback,
	output reg_num      rd,
	output reg_num      rn,
	output logic        offset_is_imm,
	output logic        undefined
);

	logic w_bit;
	logic translate_byte;

	assign pre_index = insn[24];
	assign up = insn[23];
	assign byte_access = insn[22];
	assign w_bit = insn[21];
	assign load = insn[20];

	assign rd = insn[RD_MSB:RD_LSB];
	assign rn = insn[RN_MSB:RN_LSB];

	assign offset_is_imm = !insn[25]; // I=0 means 12-bit immediate
	assign writeback = w_bit || !pre_index; // post-index always updates base

	// ldrbt/strbt
	assign translate_byte = !pre_index && w_bit && byte_access;

	assign undefined = (insn[25] && insn[4]) || translate_byte; // media space when bit 4 set

	assert property (@(insn) !pre_index |-> writeback);

endmodule

//--- hdl/core_decode_data.sv
`timescale 1ns/1ps

module core_decode_data import core_pkg::*; (
	input  logic [31:0] insn,

	output alu_op_t     op,
	output reg_num      rd,
	output reg_num      rn,
	output logic        uses_rn,
	output logic        writeback,
	output logic        update_flags,
	output logic        is_imm,
	output logic        shift_by_reg
);

	logic s_bit;

	assign s_bit = insn[20];
	assign op = alu_op_t'(insn[24:21]);
	assign rd = insn[RD_MSB:RD_LSB];
	assign rn = insn[RN_MSB:RN_LSB];
	assign is_imm = insn[25];
	assign shift_by_reg = insn[4]; // only meaningful in register form

	always_comb begin
		uses_rn = 1'b1;
		writeback = 1'b1;
		update_flags = s_bit;

		unique case (op)
			TST, TEQ, CMP, CMN: begin
				writeback = 1'b0; // result only sets flags
				update_flags = 1'b1;
			end

			MOV, MVN:
				uses_rn = 1'b0;

			default: ;
		endcase
	end

endmodule

//--- hdl/core_decode_snd.sv
`timescale 1ns/1ps

module core_decode_snd import core_pkg::*; (
	input  logic [31:0] insn,
	input  logic        is_imm,
	input  logic        ror_if_imm,

	output logic        snd_is_imm,
	output logic [11:0] imm,
	output logic [3:0]  rot,
	output reg_num      r,
	output shift_t      shift_type,
	output logic [4:0]  shift_imm,
	output logic        shift_by_reg,
	output reg_num      rs,
	output logic        undefined
);

	always_comb begin
		snd_is_imm = is_imm;
		imm = insn[11:0];
		rot = 4'd0;
		r = insn[RM_MSB:RM_LSB];
		shift_type = shift_t'(insn[6:5]);
		shift_imm = insn[11:7];
		shift_by_reg = 1'b0;
		rs = insn[RS_MSB:RS_LSB];
		undefined = 1'b0;

		if (is_imm) begin
			if (ror_if_imm) begin
				imm = {4'd0, insn[7:0]}; // 8-bit immediate rotated by 2*rot
				rot = insn[11:8];
			end
		end else if (insn[4]) begin
			shift_by_reg = 1'b1;
			shift_imm = 5'd0;
			undefined = insn[7]; // multiply / extra load-store space
		end
	end

	assert property (@(insn) shift_by_reg |-> !snd_is_imm);

endmodule

//--- hdl/core_decode_conds.sv
`timescale 1ns/1ps

module core_decode_conds import core_pkg::*; (
	input  cond_t      cond,
	input  logic [3:0] flags,

	output logic       execute,
	output logic       undefined,
	output logic       conditional
);

	logic n, z, c, v;

	assign {n, z, c, v} = flags; // nzcv order

	always_comb begin
		execute = 1'b0;
		undefined = 1'b0;
		conditional = (cond != AL);

		unique case (cond)
			EQ: execute = z;
			NE: execute = !z;
			CS: execute = c;
			CC: execute = !c;
			MI: execute = n;
			PL: execute = !n;
			VS: execute = v;
			VC: execute = !v;
			HI: execute = c && !z;
			LS: execute = !c || z;
			GE: execute = (n == v);
			LT: execute = (n != v);
			GT: execute = !z && (n == v);
			LE: execute = z || (n != v);
			AL: execute = 1'b1;
			NV: begin
				execute = 1'b0;
				undefined = 1'b1; // reserved space
			end
		endcase
	end

endmodule

//--- hdl/core_pkg.sv
package core_pkg;

	typedef logic [3:0] reg_num;

	localparam reg_num R14 = 4'd14; // link register
	localparam reg_num R15 = 4'd15; // pc

	// instruction field positions
	localparam int COND_MSB = 31;
	localparam int COND_LSB = 28;
	localparam int RN_MSB = 19;
	localparam int RN_LSB = 16;
	localparam int RD_MSB = 15;
	localparam int RD_LSB = 12;
	localparam int RS_MSB = 11;
	localparam int RS_LSB = 8;
	localparam int RM_MSB = 3;
	localparam int RM_LSB = 0;

	typedef enum logic [3:0] {
		EQ, NE, CS, CC,
		MI, PL, VS, VC,
		HI, LS, GE, LT,
		GT, LE, AL,
		NV // reserved
	} cond_t;

	typedef enum logic [3:0] {
		AND, EOR, SUB, RSB,
		ADD, ADC, SBC, RSC,
		TST, TEQ, CMP, CMN,
		ORR, MOV, BIC, MVN
	} alu_op_t;

	typedef enum logic [1:0] {
		LSL,
		LSR,
		ASR,
		ROR
	} shift_t;

	typedef enum logic [2:0] {
		G_DATA,
		G_MUL,
		G_LDST,
		G_LDM,
		G_BRANCH,
		G_UNDEF
	} insn_group_t;

endpackage
